// File: Makefile
VERILATOR   ?= verilator
TOP         := l2_cache_tb
FILELIST    := filelist.f
BUILD_FLAGS := --binary --timing --assert -Wno-fatal
LINT_FLAGS  := --lint-only --timing -Wall
OBJ_DIR     := obj_dir
LOG         := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
hdl/l2_geometry_pkg.sv
hdl/l2_control_pkg.sv
hdl/l2_request_arbiter.sv
hdl/l2_tag_store.sv
hdl/l2_data_store.sv
hdl/l2_control_fsm.sv
hdl/l2_cache.sv
verification/tb_clock_gen.sv
verification/l2_cache_assertions.sv
verification/l2_cache_tb.sv

// File: hdl/l2_cache.sv
`timescale 1ns/1ps

module l2_cache
    import l2_geometry_pkg::*;
    import l2_control_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   icache_req,
    input  logic [31:0]            icache_addr,
    output logic                   icache_addr_ok,
    output logic                   icache_data_ok,
    input  logic                   dcache_req,
    input  logic                   dcache_wr,
    input  logic [31:0]            dcache_addr,
    input  logic [word_bits-1:0]   dcache_wdata,
    input  logic [word_bits/8-1:0] dcache_wstrb,
    output logic                   dcache_addr_ok,
    output logic                   dcache_data_ok,
    output logic [line_bits-1:0]   rdata,
    output logic                   mem_req_r,
    output logic [31:0]            mem_addr_r,
    input  logic                   mem_addr_ok_r,
    output logic                   mem_req_w,
    output logic [31:0]            mem_addr_w,
    output logic [line_bits-1:0]   mem_wline,
    input  logic                   mem_addr_ok_w,
    input  logic [line_bits-1:0]   mem_rline,
    input  logic                   mem_data_ok
);

    logic                    load;
    logic                    pending;
    requester_t              buf_requester;
    logic [31:0]             buf_addr;
    logic [word_bits-1:0]    buf_wdata;
    logic [word_bits/8-1:0]  buf_wstrb;
    logic                    any_hit;
    logic [num_ways-1:0]     hit_way_onehot;
    logic [way_sel_bits-1:0] victim_way;
    logic                    victim_dirty;
    logic [tag_width-1:0]    victim_tag;
    logic [num_ways-1:0]     tag_we_onehot;
    logic [num_ways-1:0]     line_we_onehot;
    logic [num_ways-1:0]     word_we_onehot;
    logic                    refill_sel;
    logic                    set_dirty;
    logic                    clear_dirty;
    logic [num_ways-1:0]     touch_way;
    logic [way_sel_bits-1:0] resp_way;

    // Line-aligned memory addresses
    assign mem_addr_r = {buf_addr[31:index_lsb], {index_lsb{1'b0}}};
    assign mem_addr_w = {victim_tag, buf_addr[tag_lsb-1:index_lsb], {index_lsb{1'b0}}};

    l2_request_arbiter u_arbiter (
        .clk            (clk),
        .rst_n          (rst_n),
        .icache_req     (icache_req),
        .icache_addr    (icache_addr),
        .dcache_req     (dcache_req),
        .dcache_wr      (dcache_wr),
        .dcache_addr    (dcache_addr),
        .dcache_wdata   (dcache_wdata),
        .dcache_wstrb   (dcache_wstrb),
        .load           (load),
        .icache_addr_ok (icache_addr_ok),
        .dcache_addr_ok (dcache_addr_ok),
        .pending        (pending),
        .buf_requester  (buf_requester),
        .buf_addr       (buf_addr),
        .buf_wdata      (buf_wdata),
        .buf_wstrb      (buf_wstrb)
    );

    l2_tag_store u_tag_store (
        .clk            (clk),
        .rst_n          (rst_n),
        .buf_requester  (buf_requester),
        .buf_addr       (buf_addr),
        .tag_we_onehot  (tag_we_onehot),
        .set_dirty      (set_dirty),
        .clear_dirty    (clear_dirty),
        .touch_way      (touch_way),
        .any_hit        (any_hit),
        .hit_way_onehot (hit_way_onehot),
        .victim_way     (victim_way),
        .victim_dirty   (victim_dirty),
        .victim_tag     (victim_tag)
    );

    l2_data_store u_data_store (
        .clk            (clk),
        .buf_addr       (buf_addr),
        .buf_wdata      (buf_wdata),
        .buf_wstrb      (buf_wstrb),
        .mem_rline      (mem_rline),
        .line_we_onehot (line_we_onehot),
        .word_we_onehot (word_we_onehot),
        .refill_sel     (refill_sel),
        .resp_way       (resp_way),
        .victim_way     (victim_way),
        .rdata          (rdata),
        .mem_wline      (mem_wline)
    );

    l2_control_fsm u_control_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .pending        (pending),
        .buf_requester  (buf_requester),
        .any_hit        (any_hit),
        .hit_way_onehot (hit_way_onehot),
        .victim_way     (victim_way),
        .victim_dirty   (victim_dirty),
        .mem_addr_ok_r  (mem_addr_ok_r),
        .mem_addr_ok_w  (mem_addr_ok_w),
        .mem_data_ok    (mem_data_ok),
        .load           (load),
        .icache_data_ok (icache_data_ok),
        .dcache_data_ok (dcache_data_ok),
        .mem_req_r      (mem_req_r),
        .mem_req_w      (mem_req_w),
        .tag_we_onehot  (tag_we_onehot),
        .line_we_onehot (line_we_onehot),
        .word_we_onehot (word_we_onehot),
        .refill_sel     (refill_sel),
        .set_dirty      (set_dirty),
        .clear_dirty    (clear_dirty),
        .touch_way      (touch_way),
        .resp_way       (resp_way)
    );

endmodule

// File: hdl/l2_control_fsm.sv
`timescale 1ns/1ps

module l2_control_fsm
    import l2_geometry_pkg::*;
    import l2_control_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pending,
    input  requester_t              buf_requester,
    input  logic                    any_hit,
    input  logic [num_ways-1:0]     hit_way_onehot,
    input  logic [way_sel_bits-1:0] victim_way,
    input  logic                    victim_dirty,
    input  logic                    mem_addr_ok_r,
    input  logic                    mem_addr_ok_w,
    input  logic                    mem_data_ok,
    output logic                    load,
    output logic                    icache_data_ok,
    output logic                    dcache_data_ok,
    output logic                    mem_req_r,
    output logic                    mem_req_w,
    output logic [num_ways-1:0]     tag_we_onehot,
    output logic [num_ways-1:0]     line_we_onehot,
    output logic [num_ways-1:0]     word_we_onehot,
    output logic                    refill_sel,
    output logic                    set_dirty,
    output logic                    clear_dirty,
    output logic [num_ways-1:0]     touch_way,
    output logic [way_sel_bits-1:0] resp_way
);

    ctrl_state_t             state;
    ctrl_state_t             state_next;
    logic [way_sel_bits-1:0] way_q;
    logic [way_sel_bits-1:0] hit_way;
    logic [num_ways-1:0]     way_onehot;
    logic                    is_write;

    assign is_write   = (buf_requester == REQ_DWRITE);
    assign way_onehot = {{(num_ways-1){1'b0}}, 1'b1} << way_q;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit_way_onehot[w]) begin
                hit_way = way_sel_bits'(w);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Way used for the rest of the request
    always_ff @(posedge clk) begin
        if (state == ST_LOOKUP) begin
            way_q <= any_hit ? hit_way : victim_way;
        end
    end

    always_comb begin
        state_next     = state;
        load           = 1'b0;
        tag_we_onehot  = '0;
        line_we_onehot = '0;
        word_we_onehot = '0;
        refill_sel     = 1'b0;
        set_dirty      = 1'b0;
        clear_dirty    = 1'b0;
        touch_way      = '0;
        case (state)
            ST_IDLE: begin
                if (pending) begin
                    load       = 1'b1;
                    state_next = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (any_hit) begin
                    touch_way      = hit_way_onehot;
                    set_dirty      = is_write;
                    word_we_onehot = is_write ? hit_way_onehot : '0;
                    state_next     = ST_RESPOND;
                end else if (victim_dirty) begin
                    state_next = ST_WB_ADDR;
                end else begin
                    state_next = ST_FILL_ADDR;
                end
            end
            ST_WB_ADDR: begin
                if (mem_addr_ok_w) begin
                    state_next = ST_WB_WAIT;
                end
            end
            ST_WB_WAIT: begin
                if (mem_data_ok) begin
                    state_next = ST_FILL_ADDR;
                end
            end
            ST_FILL_ADDR: begin
                if (mem_addr_ok_r) begin
                    state_next = ST_FILL_WAIT;
                end
            end
            ST_FILL_WAIT: begin
                // Refill line is only valid with mem_data_ok
                if (mem_data_ok) begin
                    line_we_onehot = way_onehot;
                    word_we_onehot = is_write ? way_onehot : '0;
                    refill_sel     = 1'b1;
                    state_next     = ST_UPDATE;
                end
            end
            ST_UPDATE: begin
                tag_we_onehot = way_onehot;
                touch_way     = way_onehot;
                set_dirty     = is_write;
                clear_dirty   = !is_write;
                state_next    = ST_RESPOND;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    assign mem_req_w      = (state == ST_WB_ADDR);
    assign mem_req_r      = (state == ST_FILL_ADDR);
    assign icache_data_ok = (state == ST_RESPOND) && (buf_requester == REQ_IFETCH);
    assign dcache_data_ok = (state == ST_RESPOND) &&
                            (buf_requester == REQ_DREAD || buf_requester == REQ_DWRITE);
    assign resp_way       = way_q;

endmodule

// File: hdl/l2_control_pkg.sv
package l2_control_pkg;

    // Who owns the request buffer
    typedef enum logic [1:0] {
        REQ_NONE   = 2'd0,
        REQ_IFETCH = 2'd1,
        REQ_DREAD  = 2'd2,
        REQ_DWRITE = 2'd3
    } requester_t;

    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_LOOKUP    = 3'd1,
        ST_WB_ADDR   = 3'd2,
        ST_WB_WAIT   = 3'd3,
        ST_FILL_ADDR = 3'd4,
        ST_FILL_WAIT = 3'd5,
        ST_UPDATE    = 3'd6,
        ST_RESPOND   = 3'd7
    } ctrl_state_t;

endpackage

// File: hdl/l2_data_store.sv
`timescale 1ns/1ps

module l2_data_store
    import l2_geometry_pkg::*;
(
    input  logic                    clk,
    input  logic [31:0]             buf_addr,
    input  logic [word_bits-1:0]    buf_wdata,
    input  logic [word_bits/8-1:0]  buf_wstrb,
    input  logic [line_bits-1:0]    mem_rline,
    input  logic [num_ways-1:0]     line_we_onehot,
    input  logic [num_ways-1:0]     word_we_onehot,
    input  logic                    refill_sel,
    input  logic [way_sel_bits-1:0] resp_way,
    input  logic [way_sel_bits-1:0] victim_way,
    output logic [line_bits-1:0]    rdata,
    output logic [line_bits-1:0]    mem_wline
);

    logic [line_bits-1:0]    line_mem [num_sets][num_ways];
    logic [index_width-1:0]  idx;
    logic [offset_width-1:0] offset;

    assign idx    = buf_addr[tag_lsb-1:index_lsb];
    assign offset = buf_addr[index_lsb-1:offset_lsb];

    // Byte merge of the buffered word into one word of a line
    function automatic logic [line_bits-1:0] merge_word(
        input logic [line_bits-1:0]   line,
        input logic                   enable,
        input logic [offset_width-1:0] word_sel,
        input logic [word_bits-1:0]   wdata,
        input logic [word_bits/8-1:0] wstrb
    );
        logic [line_bits-1:0] result;
        result = line;
        for (int wd = 0; wd < words_per_line; wd++) begin
            for (int b = 0; b < word_bits / 8; b++) begin
                if (enable && wd == int'(word_sel) && wstrb[b]) begin
                    result[wd*word_bits + b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end
        return result;
    endfunction

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (line_we_onehot[w] || word_we_onehot[w]) begin
                line_mem[idx][w] <= merge_word(refill_sel ? mem_rline : line_mem[idx][w],
                                               word_we_onehot[w], offset,
                                               buf_wdata, buf_wstrb);
            end
        end
    end

    assign rdata     = line_mem[idx][resp_way];
    assign mem_wline = line_mem[idx][victim_way];

endmodule

// File: hdl/l2_geometry_pkg.sv
package l2_geometry_pkg;

    // Word and line sizes
    localparam int word_bits      = 32;
    localparam int offset_width   = 2;
    localparam int index_width    = 2;
    localparam int tag_width      = 32 - index_width - offset_width - 2;

    localparam int num_sets       = 1 << index_width;
    localparam int num_ways       = 4;
    localparam int words_per_line = 1 << offset_width;
    localparam int line_bits      = word_bits * words_per_line;

    // I side owns ways 0-1, D side ways 2-3
    localparam int half_ways      = num_ways / 2;
    localparam int way_sel_bits   = $clog2(num_ways);

    // Bit positions of the address fields
    localparam int offset_lsb     = 2;
    localparam int index_lsb      = offset_lsb + offset_width;
    localparam int tag_lsb        = index_lsb + index_width;

endpackage

// File: hdl/l2_request_arbiter.sv
`timescale 1ns/1ps

module l2_request_arbiter
    import l2_geometry_pkg::*;
    import l2_control_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   icache_req,
    input  logic [31:0]            icache_addr,
    input  logic                   dcache_req,
    input  logic                   dcache_wr,
    input  logic [31:0]            dcache_addr,
    input  logic [word_bits-1:0]   dcache_wdata,
    input  logic [word_bits/8-1:0] dcache_wstrb,
    input  logic                   load,
    output logic                   icache_addr_ok,
    output logic                   dcache_addr_ok,
    output logic                   pending,
    output requester_t             buf_requester,
    output logic [31:0]            buf_addr,
    output logic [word_bits-1:0]   buf_wdata,
    output logic [word_bits/8-1:0] buf_wstrb
);

    requester_t winner;

    // Data side wins a tie
    always_comb begin
        if (dcache_req) begin
            winner = dcache_wr ? REQ_DWRITE : REQ_DREAD;
        end else if (icache_req) begin
            winner = REQ_IFETCH;
        end else begin
            winner = REQ_NONE;
        end
    end

    assign pending        = (winner != REQ_NONE);
    assign dcache_addr_ok = load && dcache_req;
    assign icache_addr_ok = load && !dcache_req && icache_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_requester <= REQ_NONE;
        end else if (load) begin
            buf_requester <= winner;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            buf_addr  <= dcache_req ? dcache_addr : icache_addr;
            buf_wdata <= dcache_wdata;
            buf_wstrb <= dcache_wstrb;
        end
    end

endmodule

// File: hdl/l2_tag_store.sv
`timescale 1ns/1ps

module l2_tag_store
    import l2_geometry_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [1:0]              buf_requester,
    input  logic [31:0]             buf_addr,
    input  logic [num_ways-1:0]     tag_we_onehot,
    input  logic                    set_dirty,
    input  logic                    clear_dirty,
    input  logic [num_ways-1:0]     touch_way,
    output logic                    any_hit,
    output logic [num_ways-1:0]     hit_way_onehot,
    output logic [way_sel_bits-1:0] victim_way,
    output logic                    victim_dirty,
    output logic [tag_width-1:0]    victim_tag
);

    logic [tag_width-1:0]          tag_mem [num_sets][num_ways];
    logic [num_ways-1:0]           valid_q [num_sets];
    logic [num_ways-1:0]           dirty_q [num_sets];
    logic [num_ways/half_ways-1:0] plru_q  [num_sets];

    logic [index_width-1:0]  idx;
    logic [tag_width-1:0]    buf_tag;
    logic                    data_half;
    logic [way_sel_bits-1:0] half_base;

    assign idx     = buf_addr[tag_lsb-1:index_lsb];
    assign buf_tag = buf_addr[31:tag_lsb];

    // Both data requester codes have bit 1 set
    assign data_half = buf_requester[1];
    assign half_base = data_half ? way_sel_bits'(half_ways) : '0;

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit_way_onehot[w] = valid_q[idx][w] && (tag_mem[idx][w] == buf_tag);
        end
    end

    assign any_hit = |hit_way_onehot;

    // First invalid way of the half, else the one not used last
    always_comb begin
        if (!valid_q[idx][half_base]) begin
            victim_way = half_base;
        end else if (!valid_q[idx][half_base + 1'b1]) begin
            victim_way = half_base + 1'b1;
        end else begin
            victim_way = half_base + {1'b0, ~plru_q[idx][data_half]};
        end
    end

    assign victim_dirty = dirty_q[idx][victim_way];
    assign victim_tag   = tag_mem[idx][victim_way];

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (tag_we_onehot[w]) begin
                tag_mem[idx][w] <= buf_tag;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                plru_q[s]  <= '0;
            end
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                if (tag_we_onehot[w]) begin
                    valid_q[idx][w] <= 1'b1;
                end
                if (touch_way[w]) begin
                    // PLRU bit remembers the last used way of its half
                    plru_q[idx][w / half_ways] <= 1'(w % half_ways);
                    if (set_dirty) begin
                        dirty_q[idx][w] <= 1'b1;
                    end else if (clear_dirty) begin
                        dirty_q[idx][w] <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

// File: verification/l2_cache_assertions.sv
`timescale 1ns/1ps

module l2_cache_assertions (
    input logic clk,
    input logic rst_n,
    input logic icache_addr_ok,
    input logic dcache_addr_ok,
    input logic icache_data_ok,
    input logic dcache_data_ok,
    input logic mem_req_r,
    input logic mem_req_w
);

    logic icache_open;
    logic dcache_open;
    int unsigned failure_count = 0;

    // Open from addr_ok until data_ok
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            icache_open <= 1'b0;
            dcache_open <= 1'b0;
        end else begin
            if (icache_addr_ok) begin
                icache_open <= 1'b1;
            end else if (icache_data_ok) begin
                icache_open <= 1'b0;
            end
            if (dcache_addr_ok) begin
                dcache_open <= 1'b1;
            end else if (dcache_data_ok) begin
                dcache_open <= 1'b0;
            end
        end
    end

    single_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(icache_addr_ok && dcache_addr_ok))
        else begin
            failure_count++;
            $error("addr_ok given to both L1 ports in one cycle");
        end

    icache_data_after_addr: assert property (@(posedge clk) disable iff (!rst_n)
        icache_data_ok |-> icache_open)
        else begin
            failure_count++;
            $error("icache data_ok without an accepted request");
        end

    dcache_data_after_addr: assert property (@(posedge clk) disable iff (!rst_n)
        dcache_data_ok |-> dcache_open)
        else begin
            failure_count++;
            $error("dcache data_ok without an accepted request");
        end

    one_mem_request: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_req_r && mem_req_w))
        else begin
            failure_count++;
            $error("memory read and write requested together");
        end

endmodule

bind l2_cache l2_cache_assertions u_assertions (
    .clk            (clk),
    .rst_n          (rst_n),
    .icache_addr_ok (icache_addr_ok),
    .dcache_addr_ok (dcache_addr_ok),
    .icache_data_ok (icache_data_ok),
    .dcache_data_ok (dcache_data_ok),
    .mem_req_r      (mem_req_r),
    .mem_req_w      (mem_req_w)
);

// File: verification/l2_cache_tb.sv
`timescale 1ns/1ps

module l2_cache_tb
    import l2_geometry_pkg::*;
();

    localparam int          timeout_cycles = 200;
    localparam logic [31:0] pattern_key    = 32'ha5a5_0000;
    localparam logic [31:0] random_seed    = 32'hbf90_c834;

    localparam int strobe_iaddr = 0;
    localparam int strobe_idata = 1;
    localparam int strobe_daddr = 2;
    localparam int strobe_ddata = 3;

    // Memory model phases
    localparam int mm_idle   = 0;
    localparam int mm_delay  = 1;
    localparam int mm_accept = 2;
    localparam int mm_done   = 3;

    logic                   clk;
    logic                   rst_n;
    logic                   icache_req;
    logic [31:0]            icache_addr;
    logic                   icache_addr_ok;
    logic                   icache_data_ok;
    logic                   dcache_req;
    logic                   dcache_wr;
    logic [31:0]            dcache_addr;
    logic [word_bits-1:0]   dcache_wdata;
    logic [word_bits/8-1:0] dcache_wstrb;
    logic                   dcache_addr_ok;
    logic                   dcache_data_ok;
    logic [line_bits-1:0]   rdata;
    logic                   mem_req_r;
    logic [31:0]            mem_addr_r;
    logic                   mem_addr_ok_r;
    logic                   mem_req_w;
    logic [31:0]            mem_addr_w;
    logic [line_bits-1:0]   mem_wline;
    logic                   mem_addr_ok_w;
    logic [line_bits-1:0]   mem_rline;
    logic                   mem_data_ok;

    logic [word_bits-1:0]   mem_words [logic [31:0]];
    time                    icache_accept_time;
    time                    dcache_accept_time;

    tb_clock_gen u_clock_gen (.clk(clk));

    l2_cache uut (.*);

    // Unwritten words hold their address XOR the key
    function automatic logic [word_bits-1:0] read_mem_word(input logic [31:0] addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        return addr ^ pattern_key;
    endfunction

    function automatic logic strobe_value(input int sel);
        case (sel)
            strobe_iaddr: return icache_addr_ok;
            strobe_idata: return icache_data_ok;
            strobe_daddr: return dcache_addr_ok;
            default:      return dcache_data_ok;
        endcase
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_line(input logic [line_bits-1:0] actual,
                              input logic [line_bits-1:0] expected, input string what);
        if (actual !== expected) begin
            fail_now($sformatf("MISMATCH at %0d ns: %s expected %h got %h",
                               $time, what, expected, actual));
        end
    endtask

    task automatic check_word(input logic [word_bits-1:0] actual,
                              input logic [word_bits-1:0] expected, input string what);
        if (actual !== expected) begin
            fail_now($sformatf("MISMATCH at %0d ns: %s expected %h got %h",
                               $time, what, expected, actual));
        end
    endtask

    always @(negedge clk) begin
        if (uut.u_assertions.failure_count != 0) begin
            fail_now("A handshake assertion on the cache ports failed");
        end
    end

    // Sampled at the falling edge
    task automatic wait_for_strobe(input int sel, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!strobe_value(sel)) begin
            if (cycles >= timeout_cycles) begin
                fail_now($sformatf("Timeout at %0d ns waiting for %s", $time, what));
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    task automatic run_ifetch(input logic [31:0] addr, input logic [line_bits-1:0] expected);
        @(posedge clk);
        #1;
        icache_req  = 1'b1;
        icache_addr = addr;
        wait_for_strobe(strobe_iaddr, "icache addr_ok");
        icache_accept_time = $time;
        @(posedge clk);
        #1;
        icache_req = 1'b0;
        wait_for_strobe(strobe_idata, "icache data_ok");
        check_line(rdata, expected, $sformatf("fetch of %h", addr));
    endtask

    task automatic run_daccess(
        input logic                   wr,
        input logic [31:0]            addr,
        input logic [word_bits-1:0]   wdata,
        input logic [word_bits/8-1:0] wstrb,
        input logic [line_bits-1:0]   expected
    );
        @(posedge clk);
        #1;
        dcache_req   = 1'b1;
        dcache_wr    = wr;
        dcache_addr  = addr;
        dcache_wdata = wdata;
        dcache_wstrb = wstrb;
        wait_for_strobe(strobe_daddr, "dcache addr_ok");
        dcache_accept_time = $time;
        @(posedge clk);
        #1;
        dcache_req = 1'b0;
        wait_for_strobe(strobe_ddata, "dcache data_ok");
        if (!wr) begin
            check_line(rdata, expected, $sformatf("data read of %h", addr));
        end
    endtask

    initial begin : memory_model
        int unsigned          delay_left;
        int                   phase;
        logic                 grant;
        logic                 write_req;
        logic [line_bits-1:0] next_rline;
        mem_addr_ok_r = 1'b0;
        mem_addr_ok_w = 1'b0;
        mem_data_ok   = 1'b0;
        mem_rline     = '0;
        next_rline    = '0;
        write_req     = 1'b0;
        delay_left    = 0;
        phase         = mm_idle;
        void'($urandom(random_seed));
        forever begin
            @(negedge clk);
            grant = 1'b0;
            case (phase)
                mm_idle: begin
                    if (rst_n && (mem_req_r || mem_req_w)) begin
                        write_req  = mem_req_w;
                        delay_left = $urandom_range(3, 0);
                        grant      = (delay_left == 0);
                        phase      = grant ? mm_accept : mm_delay;
                    end
                end
                mm_delay: begin
                    delay_left--;
                    grant = (delay_left == 0);
                    phase = grant ? mm_accept : mm_delay;
                end
                mm_accept: begin
                    // DUT takes addr_ok at the coming edge
                    for (int i = 0; i < words_per_line; i++) begin
                        if (write_req) begin
                            mem_words[mem_addr_w + 32'(4 * i)] =
                                mem_wline[i*word_bits +: word_bits];
                        end else begin
                            next_rline[i*word_bits +: word_bits] =
                                read_mem_word(mem_addr_r + 32'(4 * i));
                        end
                    end
                    phase = mm_done;
                end
                default: begin
                    phase = mm_idle;
                end
            endcase
            @(posedge clk);
            #1;
            mem_addr_ok_r = grant && !write_req;
            mem_addr_ok_w = grant && write_req;
            mem_data_ok   = (phase == mm_done);
            mem_rline     = next_rline;
        end
    end

    initial begin : run_tests
        int                   fd;
        int                   fields;
        string                text;
        logic [7:0]           op;
        logic [31:0]          addr;
        logic [31:0]          wdata;
        logic [3:0]           wstrb;
        logic [line_bits-1:0] expected;
        logic                 pair_pending;
        logic [31:0]          pair_addr;
        logic [line_bits-1:0] pair_expected;
        rst_n        = 1'b0;
        icache_req   = 1'b0;
        icache_addr  = '0;
        dcache_req   = 1'b0;
        dcache_wr    = 1'b0;
        dcache_addr  = '0;
        dcache_wdata = '0;
        dcache_wstrb = '0;
        pair_pending = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fd = $fopen("verification/l2_cache_tests.txt", "r");
        if (fd == 0) begin
            fail_now("Could not open the test file verification/l2_cache_tests.txt");
        end
        while (!$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            if (text.len() < 2 || text[0] == "#") begin
                continue;
            end
            fields = $sscanf(text, "%c %h %h %h %h", op, addr, wdata, wstrb, expected);
            if (fields != 5) begin
                fail_now($sformatf("Malformed line in the test file: %s", text));
            end
            case (op)
                "I": run_ifetch(addr, expected);
                "P": begin
                    pair_pending  = 1'b1;
                    pair_addr     = addr;
                    pair_expected = expected;
                end
                "R", "W": begin
                    if (pair_pending) begin
                        fork
                            run_ifetch(pair_addr, pair_expected);
                            run_daccess(op == "W", addr, wdata, wstrb, expected);
                        join
                        pair_pending = 1'b0;
                        if (dcache_accept_time >= icache_accept_time) begin
                            fail_now("Data request was not accepted before the paired fetch");
                        end
                    end else begin
                        run_daccess(op == "W", addr, wdata, wstrb, expected);
                    end
                end
                "C": check_word(read_mem_word(addr), expected[word_bits-1:0],
                                $sformatf("memory word %h", addr));
                default: fail_now($sformatf("Unknown operation %c in the test file", op));
            endcase
        end
        $fclose(fd);
        if (uut.u_assertions.failure_count != 0) begin
            fail_now("A handshake assertion on the cache ports failed");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// File: verification/l2_cache_tests.txt
# op addr wdata wstrb expected (hex; expected is a line for I/P/R, a word for C, 0 for W)
# I fetch, R data read, W data write, P fetch issued with the next data line, C memory word
I 00001000 00000000 0 a5a5100ca5a51008a5a51004a5a51000
I 00001004 00000000 0 a5a5100ca5a51008a5a51004a5a51000
R 00002010 00000000 0 a5a5201ca5a52018a5a52014a5a52010
R 00002014 00000000 0 a5a5201ca5a52018a5a52014a5a52010
W 00002018 11223344 6 0
R 00002010 00000000 0 a5a5201ca5223318a5a52014a5a52010
I 0000201c 00000000 0 a5a5201ca5223318a5a52014a5a52010
P 00003020 00000000 0 a5a5302ca5a53028a5a53024a5a53020
R 00004020 00000000 0 a5a5402ca5a54028a5a54024a5a54020
R 00005010 00000000 0 a5a5501ca5a55018a5a55014a5a55010
R 00006010 00000000 0 a5a5601ca5a56018a5a56014a5a56010
C 00002018 00000000 0 a5223318
C 00002010 00000000 0 a5a52010
W 00007030 deadbeef 9 0
I 00008030 00000000 0 a5a5803ca5a58038a5a58034a5a58030
I 00009030 00000000 0 a5a5903ca5a59038a5a59034a5a59030
I 0000a030 00000000 0 a5a5a03ca5a5a038a5a5a034a5a5a030
R 00007030 00000000 0 a5a5703ca5a57038a5a57034dea570ef
C 00007030 00000000 0 a5a57030
R 0000b030 00000000 0 a5a5b03ca5a5b038a5a5b034a5a5b030
R 0000c030 00000000 0 a5a5c03ca5a5c038a5a5c034a5a5c030
C 00007030 00000000 0 dea570ef
C 00007034 00000000 0 a5a57034

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

endmodule
